/* Bender.yml */
package:
  name: xt_chipset_glue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/chipset_bus_pkg.sv
      - verilog/chipset_cfg_pkg.sv
      - verilog/bus_cycle_if.sv
      - verilog/chipset_config.sv
      - verilog/refresh_request.sv
      - verilog/ready_control.sv
      - verilog/data_bus_steer.sv
      - verilog/xt_chipset_glue.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/chipset_checker.sv
      - dv/tb_chipset.sv

/* dv/chipset_checker.sv */
// Watches the glue outputs and compares them at each check_now pulse.
// Counts wb_ack and processor_ready low samples between clear_counts and check_now.
// wb_dat_r is captured on every edge that samples wb_ack high.
module chipset_checker
    import chipset_bus_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         clear_counts,
    input  logic         check_now,
    input  logic [159:0] test_name,
    input  logic [3:0]   check_mask,
    input  data_byte_t   exp_data,
    input  logic         exp_dir,
    input  dma_lines_t   exp_dma,
    input  data_byte_t   exp_wb,
    input  logic [7:0]   exp_low,
    input  logic [7:0]   exp_acks,
    input  data_byte_t   data_to_cpu,
    input  logic         data_bus_direction,
    input  dma_lines_t   dma_request,
    input  logic         wb_ack,
    input  data_byte_t   wb_dat_r,
    input  logic         processor_ready,
    output int           pass_count,
    output int           fail_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CHECK_DATA  = 0;
    localparam int CHECK_DMA   = 1;
    localparam int CHECK_READY = 2;
    localparam int CHECK_READ  = 3;

    logic [7:0] ack_count;
    logic [7:0] low_count;
    logic [7:0] acks_now;
    logic [7:0] low_now;
    data_byte_t captured;
    data_byte_t read_now;
    int         errors;

    task automatic print_mismatch(input string signal, input logic [7:0] expected,
                                  input logic [7:0] actual);
        $display("ERR %0s %0s expected 0x%02h got 0x%02h", test_name, signal,
                 expected, actual);
        errors++;
    endtask

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            ack_count  <= '0;
            low_count  <= '0;
            captured   <= '0;
            pass_count <= 0;
            fail_count <= 0;
        end else begin
            acks_now = ack_count + {7'd0, wb_ack};
            low_now  = low_count + {7'd0, ~processor_ready};
            read_now = wb_ack ? wb_dat_r : captured;
            captured <= read_now;
            if (check_now) begin
                errors = 0;
                if (check_mask[CHECK_DATA]) begin
                    if (data_to_cpu !== exp_data)
                        print_mismatch("data_to_cpu", exp_data, data_to_cpu);
                    if (data_bus_direction !== exp_dir)
                        print_mismatch("data_bus_direction", {7'd0, exp_dir},
                                       {7'd0, data_bus_direction});
                end
                if (check_mask[CHECK_DMA] && dma_request !== exp_dma)
                    print_mismatch("dma_request", {4'd0, exp_dma}, {4'd0, dma_request});
                if (check_mask[CHECK_READY] && low_now !== exp_low)
                    print_mismatch("processor_ready low cycles", exp_low, low_now);
                if (acks_now != exp_acks) begin
                    $display("%0s saw %0d Wishbone acknowledges where %0d were due",
                             test_name, acks_now, exp_acks);
                    errors++;
                end else if (check_mask[CHECK_READ] && read_now !== exp_wb) begin
                    print_mismatch("wb_dat_r", exp_wb, read_now);
                end
                if (errors == 0) begin
                    $display("PASS %0s", test_name);
                    pass_count <= pass_count + 1;
                end else begin
                    $display("FAIL %0s", test_name);
                    fail_count <= fail_count + 1;
                end
                ack_count <= '0;
                low_count <= '0;
            end else if (clear_counts) begin
                ack_count <= '0;
                low_count <= '0;
            end else begin
                ack_count <= acks_now;
                low_count <= low_now;
            end
        end
    end

endmodule

/* dv/tb_chipset.sv */
// Table driven testbench for the XT bus glue. Inputs change 1 ns after the
// rising edge. The run stops at twice the table's cycle budget plus 20.
module tb_chipset
    import chipset_bus_pkg::*;
    import chipset_cfg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [3:0] MASK_DATA  = 4'b0001;
    localparam logic [3:0] MASK_DMA   = 4'b0010;
    localparam logic [3:0] MASK_READY = 4'b0100;
    localparam logic [3:0] MASK_READ  = 4'b1000;

    typedef enum logic [2:0] {
        OP_STEER, OP_WB_WRITE, OP_WB_READ, OP_TIMER, OP_DMA_ACK, OP_WAIT, OP_IDLE
    } op_e;

    typedef struct packed {
        logic [159:0] name;
        op_e          op;
        logic [7:0]   arg;
        cfg_addr_t    adr;
        logic         valid;
        data_byte_t   cdata;
        logic         ram_rd;
        data_byte_t   rdata;
        logic         ext_dir;
        data_byte_t   edata;
        logic [3:0]   mask;
        data_byte_t   exp_data;
        logic         exp_dir;
        dma_lines_t   exp_dma;
        data_byte_t   exp_wb;
        logic [7:0]   exp_low;
        logic [7:0]   exp_acks;
        logic [7:0]   cycles;
    } entry_t;

    logic clock, reset, timer_refresh_tick;
    dma_lines_t dma_request_ext, dma_acknowledge_n, dma_request;
    logic io_read_n, io_write_n, memory_read_n, memory_write_n, ram_select_n;
    logic io_channel_ready, memory_access_ready, processor_ready;
    data_byte_t chipset_data, ram_data, ext_data, data_to_cpu, wb_dat_w, wb_dat_r;
    logic chipset_data_valid, ext_direction, data_bus_direction;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    cfg_addr_t wb_adr;
    logic clear_counts, check_now;
    entry_t current, table_q[$];
    int pass_count, fail_count, cycle_count, cycle_limit;

    xt_chipset_glue u_xt_chipset_glue (.*);

    chipset_checker u_chipset_checker (
        .clock              (clock),
        .reset              (reset),
        .clear_counts       (clear_counts),
        .check_now          (check_now),
        .test_name          (current.name),
        .check_mask         (current.mask),
        .exp_data           (current.exp_data),
        .exp_dir            (current.exp_dir),
        .exp_dma            (current.exp_dma),
        .exp_wb             (current.exp_wb),
        .exp_low            (current.exp_low),
        .exp_acks           (current.exp_acks),
        .data_to_cpu        (data_to_cpu),
        .data_bus_direction (data_bus_direction),
        .dma_request        (dma_request),
        .wb_ack             (wb_ack),
        .wb_dat_r           (wb_dat_r),
        .processor_ready    (processor_ready),
        .pass_count         (pass_count),
        .fail_count         (fail_count)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic entry_t steer(input logic [159:0] name, input logic valid,
            input data_byte_t cdata, input logic ram_rd, input data_byte_t rdata,
            input logic ext_dir, input data_byte_t edata, input data_byte_t exp_data,
            input logic exp_dir);
        entry_t e;
        e = '0;
        e.name = name;
        e.op = OP_STEER;
        e.mask = MASK_DATA;
        e.cycles = 6;
        e.valid = valid;
        e.cdata = cdata;
        e.ram_rd = ram_rd;
        e.rdata = rdata;
        e.ext_dir = ext_dir;
        e.edata = edata;
        e.exp_data = exp_data;
        e.exp_dir = exp_dir;
        return e;
    endfunction

    // Read data is compared for reads only
    function automatic entry_t wb_access(input logic [159:0] name, input logic write,
            input cfg_addr_t adr, input data_byte_t value);
        entry_t e;
        e = '0;
        e.name = name;
        e.op = write ? OP_WB_WRITE : OP_WB_READ;
        e.adr = adr;
        e.arg = value;
        e.mask = write ? 4'b0000 : MASK_READ;
        e.exp_wb = value;
        e.exp_acks = 1;
        e.cycles = 10;
        return e;
    endfunction

    // OP_TIMER sets dma_request_ext from arg, OP_IDLE waits arg cycles
    function automatic entry_t dma_step(input logic [159:0] name, input op_e op,
            input logic [7:0] arg, input dma_lines_t exp_dma);
        entry_t e;
        e = '0;
        e.name = name;
        e.op = op;
        e.arg = arg;
        e.mask = MASK_DMA;
        e.exp_dma = exp_dma;
        e.cycles = 8 + arg;
        return e;
    endfunction

    // arg is the number of cycles memory_access_ready is held low
    function automatic entry_t wait_cycle(input logic [159:0] name, input logic [7:0] hold,
            input logic [7:0] exp_low);
        entry_t e;
        e = '0;
        e.name = name;
        e.op = OP_WAIT;
        e.arg = hold;
        e.mask = MASK_READY;
        e.exp_low = exp_low;
        e.cycles = 16 + hold + exp_low;
        return e;
    endfunction

    // Advance to 1 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    // One clock of strobe, the acknowledge is due on that edge
    task automatic wishbone_transfer(input logic write, input cfg_addr_t adr,
            input data_byte_t value);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = write;
        wb_adr = adr;
        wb_dat_w = value;
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        int waited;
        waited = 0;
        // Gap so the ready FSM is idle, then start counting for this entry
        {io_read_n, io_write_n, memory_read_n, memory_write_n, ram_select_n} = '1;
        io_channel_ready = 1'b1;
        memory_access_ready = 1'b1;
        repeat (2) next_cycle();
        clear_counts = 1'b1;
        next_cycle();
        clear_counts = 1'b0;
        case (e.op)
            OP_STEER: begin
                chipset_data_valid = e.valid;
                chipset_data = e.cdata;
                ram_data = e.rdata;
                memory_read_n = ~e.ram_rd;
                ram_select_n = ~e.ram_rd;
                ext_direction = e.ext_dir;
                ext_data = e.edata;
            end
            OP_WB_WRITE: wishbone_transfer(1'b1, e.adr, e.arg);
            OP_WB_READ:  wishbone_transfer(1'b0, e.adr, '0);
            OP_TIMER: begin
                dma_request_ext = e.arg[3:0];
                timer_refresh_tick = 1'b0;
                next_cycle();
                timer_refresh_tick = 1'b1;
                next_cycle();
            end
            OP_DMA_ACK: begin
                dma_acknowledge_n[0] = 1'b0;
                next_cycle();
                dma_acknowledge_n[0] = 1'b1;
            end
            OP_WAIT: begin
                io_read_n = 1'b0;
                if (e.arg != 0) memory_access_ready = 1'b0;
                repeat ((e.arg != 0) ? e.arg : 1) next_cycle();
                memory_access_ready = 1'b1;
                while (!processor_ready && waited < 16) begin
                    next_cycle();
                    waited++;
                end
                io_read_n = 1'b1;
            end
            default: repeat (e.arg) next_cycle();
        endcase
        check_now = 1'b1;
        next_cycle();
        check_now = 1'b0;
    endtask

    always @(posedge clock) begin
        if (!reset && cycle_limit > 0) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                $display("Timeout: run did not finish within %0d cycles", cycle_limit);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    initial begin
        reset = 1'b1;
        timer_refresh_tick = 1'b1;
        dma_request_ext = '0;
        dma_acknowledge_n = '1;
        {io_read_n, io_write_n, memory_read_n, memory_write_n, ram_select_n} = '1;
        io_channel_ready = 1'b1;
        memory_access_ready = 1'b1;
        chipset_data = '0;
        ram_data = '0;
        ext_data = '0;
        chipset_data_valid = 1'b0;
        ext_direction = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        clear_counts = 1'b0;
        check_now = 1'b0;
        current = '0;
        cycle_count = 0;
        cycle_limit = 0;

        table_q.push_back(dma_step("timer_high_reset", OP_IDLE, 3, 4'b0000));
        table_q.push_back(steer("steer_chipset", 1, 8'ha5, 1, 8'h3c, 1, 8'h77, 8'ha5, 0));
        table_q.push_back(steer("steer_ram", 0, 8'ha5, 1, 8'h3c, 1, 8'h77, 8'h3c, 0));
        table_q.push_back(steer("steer_ext", 0, 8'ha5, 0, 8'h3c, 1, 8'h77, 8'h77, 1));
        table_q.push_back(steer("steer_zero", 0, 8'ha5, 0, 8'h3c, 0, 8'h77, 8'h00, 0));
        table_q.push_back(wb_access("ctrl_reset", 0, CTRL, 8'h03));
        table_q.push_back(dma_step("refresh_rise", OP_TIMER, 8'h0a, 4'b1011));
        table_q.push_back(dma_step("refresh_ack", OP_DMA_ACK, 0, 4'b1010));
        table_q.push_back(dma_step("refresh_rise_2", OP_TIMER, 8'h04, 4'b0101));
        table_q.push_back(dma_step("refresh_ack_2", OP_DMA_ACK, 0, 4'b0100));
        table_q.push_back(wb_access("count_two", 0, REFRESH_COUNT, 8'h02));
        table_q.push_back(wb_access("count_clear", 1, REFRESH_COUNT, 8'hff));
        table_q.push_back(wb_access("count_zero", 0, REFRESH_COUNT, 8'h00));
        table_q.push_back(wb_access("refresh_off", 1, CTRL, 8'h02));
        table_q.push_back(dma_step("refresh_blocked", OP_TIMER, 8'h00, 4'b0000));
        table_q.push_back(wb_access("wait_zero", 1, CTRL, 8'h00));
        table_q.push_back(wait_cycle("ready_wait_0", 0, 0));
        table_q.push_back(wb_access("wait_one", 1, CTRL, 8'h02));
        table_q.push_back(wait_cycle("ready_wait_1", 0, 1));
        table_q.push_back(wb_access("wait_five", 1, CTRL, 8'h0a));
        table_q.push_back(wait_cycle("ready_wait_5", 0, 5));
        table_q.push_back(wb_access("wait_one_again", 1, CTRL, 8'h02));
        // Ready low until memory_access_ready rises, one cycle short of the hold
        table_q.push_back(wait_cycle("ready_backpressure", 5, 4));
        table_q.push_back(wb_access("ctrl_readback", 0, CTRL, 8'h02));

        foreach (table_q[i]) cycle_limit += table_q[i].cycles;
        cycle_limit = 2 * cycle_limit + 20;

        repeat (5) @(posedge clock);
        #1 reset = 1'b0;

        foreach (table_q[i]) begin
            current = table_q[i];
            run_entry(current);
        end
        next_cycle();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == table_q.size()) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* include/chipset_params.svh */
// Widths and reset values shared by the bus glue and its configuration block.
// The data path is the 8-bit bus of an 8088-class CPU; changing
// CHIPSET_DATA_WIDTH also changes the Wishbone data width.
`ifndef CHIPSET_PARAMS_SVH
`define CHIPSET_PARAMS_SVH

// CPU data byte
`define CHIPSET_DATA_WIDTH 8

// DMA channels seen by the glue, channel 0 is memory refresh
`define CHIPSET_DMA_CHANNELS 4

// Wait-state count, must fit in CTRL bits 7..1
`define CHIPSET_WAIT_BITS 3

// Served refresh counter, wraps at its maximum
`define CHIPSET_REFRESH_COUNT_BITS 8

// Word address of the configuration registers
`define CHIPSET_CFG_ADDR_BITS 2

// Wait states inserted after reset
`define CHIPSET_WAIT_RESET 1

`endif

/* src.f */
+incdir+include
verilog/chipset_bus_pkg.sv
verilog/chipset_cfg_pkg.sv
verilog/bus_cycle_if.sv
verilog/chipset_config.sv
verilog/refresh_request.sv
verilog/ready_control.sv
verilog/data_bus_steer.sv
verilog/xt_chipset_glue.sv
dv/chipset_checker.sv
dv/tb_chipset.sv

/* verilog/bus_cycle_if.sv */
// Bus command strobes and RAM select of the CPU side, all active low.
// Purely combinational bundle, no clock inside.
interface bus_cycle_if;

    logic io_read_n;
    logic io_write_n;
    logic memory_read_n;
    logic memory_write_n;
    logic ram_select_n;

    // Driven from the top-level ports
    modport source (
        output io_read_n,
        output io_write_n,
        output memory_read_n,
        output memory_write_n,
        output ram_select_n
    );

    // Ready generation only needs the command strobes
    modport command (
        input io_read_n,
        input io_write_n,
        input memory_read_n,
        input memory_write_n
    );

    // Read data steering
    modport read_path (
        input memory_read_n,
        input ram_select_n
    );

endinterface

/* verilog/chipset_bus_pkg.sv */
// Types of the CPU-side bus and of the processor ready FSM.
// Widths come from the shared parameter header.
`include "chipset_params.svh"

package chipset_bus_pkg;

    // One byte on the CPU data bus
    typedef logic [`CHIPSET_DATA_WIDTH-1:0] data_byte_t;

    // Request or acknowledge lines, one bit per DMA channel
    typedef logic [`CHIPSET_DMA_CHANNELS-1:0] dma_lines_t;

    // Ready FSM
    // idle     no command in progress, ready high
    // waiting  inserting wait states or waiting for external ready
    // holding  ready given, waiting for the command to end
    typedef enum logic [1:0] {
        READY_IDLE,
        READY_WAITING,
        READY_HOLDING
    } ready_state_e;

endpackage

/* verilog/chipset_cfg_pkg.sv */
// Types and register map of the Wishbone configuration block.
// Registers are byte wide; addresses 2 and 3 are unmapped.
`include "chipset_params.svh"

package chipset_cfg_pkg;

    typedef logic [`CHIPSET_CFG_ADDR_BITS-1:0] cfg_addr_t;
    typedef logic [`CHIPSET_WAIT_BITS-1:0] wait_count_t;
    typedef logic [`CHIPSET_REFRESH_COUNT_BITS-1:0] refresh_count_t;

    // Register word addresses
    typedef enum logic [`CHIPSET_CFG_ADDR_BITS-1:0] {
        CTRL          = 2'd0,
        REFRESH_COUNT = 2'd1
    } cfg_reg_e;

    // CTRL fields, upper bits read as zero
    localparam int unsigned CTRL_ENABLE_BIT = 0;
    localparam int unsigned CTRL_WAIT_LSB   = 1;
    localparam int unsigned CTRL_WAIT_MSB   = CTRL_WAIT_LSB + `CHIPSET_WAIT_BITS - 1;

endpackage

/* verilog/chipset_config.sv */
// Wishbone classic slave holding refresh enable, wait states and the served
// refresh counter. Single-cycle transfers only; wb_ack follows the strobe by
// one clock and the master must drop wb_stb after it. No stall support.
module chipset_config
    import chipset_bus_pkg::*;
    import chipset_cfg_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  cfg_addr_t      wb_adr,
    input  data_byte_t     wb_dat_w,
    output data_byte_t     wb_dat_r,
    output logic           wb_ack,
    input  logic           refresh_served,
    output logic           refresh_enable,
    output wait_count_t    wait_states
);

`include "chipset_params.svh"

    logic           access;
    logic           write_ctrl;
    logic           write_count;
    data_byte_t     read_data;
    refresh_count_t refresh_count;

    // New transfer, ignoring the cycle that is already being acknowledged
    assign access      = wb_cyc & wb_stb & ~wb_ack;
    assign write_ctrl  = access & wb_we & (wb_adr == CTRL);
    assign write_count = access & wb_we & (wb_adr == REFRESH_COUNT);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            refresh_enable <= 1'b1;
            wait_states    <= wait_count_t'(`CHIPSET_WAIT_RESET);
        end else if (write_ctrl) begin
            refresh_enable <= wb_dat_w[CTRL_ENABLE_BIT];
            wait_states    <= wb_dat_w[CTRL_WAIT_MSB:CTRL_WAIT_LSB];
        end
    end

    // Clearing write takes priority over a served pulse
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            refresh_count <= '0;
        end else if (write_count) begin
            refresh_count <= '0;
        end else if (refresh_served) begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    always_comb begin
        read_data = '0;
        case (wb_adr)
            CTRL: begin
                read_data[CTRL_ENABLE_BIT]             = refresh_enable;
                read_data[CTRL_WAIT_MSB:CTRL_WAIT_LSB] = wait_states;
            end
            REFRESH_COUNT: read_data = data_byte_t'(refresh_count);
            default: read_data = '0;
        endcase
    end

    // Captured with the acknowledge, held until the next transfer
    always_ff @(posedge clock) begin
        if (access) begin
            wb_dat_r <= read_data;
        end
    end

    // Master ends the strobe once the transfer is acknowledged
    stb_dropped_after_ack: assert property (
        @(posedge clock) disable iff (reset) wb_ack |=> !wb_stb
    ) else $error("wb_stb still high in the cycle after wb_ack");

endmodule

/* verilog/data_bus_steer.sv */
// Read data multiplexer towards the CPU, fixed priority:
// chipset registers, RAM read, external bus, then zero.
// data_bus_direction is high only when the external bus drives the CPU.
module data_bus_steer
    import chipset_bus_pkg::*;
(
    bus_cycle_if.read_path bus,
    input  data_byte_t     chipset_data,
    input  logic           chipset_data_valid,
    input  data_byte_t     ram_data,
    input  data_byte_t     ext_data,
    input  logic           ext_direction,
    output data_byte_t     data_to_cpu,
    output logic           data_bus_direction
);

    logic ram_read;

    assign ram_read = ~bus.ram_select_n & ~bus.memory_read_n;

    always_comb begin
        data_to_cpu        = '0;
        data_bus_direction = 1'b0;
        if (chipset_data_valid) begin
            data_to_cpu = chipset_data;
        end else if (ram_read) begin
            data_to_cpu = ram_data;
        end else if (ext_direction) begin
            data_to_cpu        = ext_data;
            data_bus_direction = 1'b1;
        end
    end

endmodule

/* verilog/ready_control.sv */
// Processor ready generator. Each new bus command gets the configured number
// of wait states, then waits for channel and memory ready. A command that
// stays active counts as one bus cycle until all strobes return high.
module ready_control
    import chipset_bus_pkg::*;
    import chipset_cfg_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    bus_cycle_if.command  bus,
    input  wait_count_t   wait_states,
    input  logic          io_channel_ready,
    input  logic          memory_access_ready,
    output logic          processor_ready
);

    ready_state_e state;
    wait_count_t  wait_count;
    logic         command_active;
    logic         external_ready;

    assign command_active = ~(bus.io_read_n & bus.io_write_n &
                              bus.memory_read_n & bus.memory_write_n);
    assign external_ready = io_channel_ready & memory_access_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= READY_IDLE;
            wait_count <= '0;
        end else begin
            case (state)
                READY_IDLE: begin
                    if (command_active) begin
                        state      <= READY_WAITING;
                        wait_count <= wait_states;
                    end
                end
                READY_WAITING: begin
                    if (!command_active) begin
                        state <= READY_IDLE;
                    end else if (wait_count != '0) begin
                        wait_count <= wait_count - 1'b1;
                    end else if (external_ready) begin
                        state <= READY_HOLDING;
                    end
                end
                READY_HOLDING: begin
                    if (!command_active) begin
                        state <= READY_IDLE;
                    end
                end
                default: state <= READY_IDLE;
            endcase
        end
    end

    // Low while counting down, then follows the external ready inputs
    always_comb begin
        if (state == READY_WAITING) begin
            processor_ready = (wait_count == '0) & external_ready;
        end else begin
            processor_ready = 1'b1;
        end
    end

endmodule

/* verilog/refresh_request.sv */
// DMA channel 0 refresh request from the timer channel 1 output.
// The timer output must already be synchronous to clock. A level that is
// high out of reset is not taken as an edge.
module refresh_request (
    input  logic clock,
    input  logic reset,
    input  logic timer_refresh_tick,
    input  logic refresh_enable,
    input  logic dma0_acknowledge_n,
    output logic refresh_request,
    output logic refresh_served
);

    logic timer_prev;
    logic timer_rise;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            timer_prev <= 1'b1;
        end else begin
            timer_prev <= timer_refresh_tick;
        end
    end

    assign timer_rise = timer_refresh_tick & ~timer_prev;

    // Acknowledge clears before a new edge can set
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            refresh_request <= 1'b0;
            refresh_served  <= 1'b0;
        end else begin
            refresh_served <= refresh_request & ~dma0_acknowledge_n;
            if (~dma0_acknowledge_n) begin
                refresh_request <= 1'b0;
            end else if (timer_rise & refresh_enable) begin
                refresh_request <= 1'b1;
            end
        end
    end

    // A new request needs a low then high timer sample, enabled and not acknowledged
    set_on_timer_edge: assert property (
        @(posedge clock) disable iff (reset)
        $rose(refresh_request) |->
            $past(timer_refresh_tick && refresh_enable && dma0_acknowledge_n) &&
            !$past(timer_refresh_tick, 2)
    ) else $error("refresh request set without an enabled timer rising edge");

endmodule

/* verilog/xt_chipset_glue.sv */
// Top of the XT bus glue: refresh request, ready generation, read steering
// and the Wishbone configuration block. Single clock domain.
// DMA channels 1 to 3 pass through; the DMA controller sits outside.
`include "chipset_params.svh"

module xt_chipset_glue
    import chipset_bus_pkg::*;
    import chipset_cfg_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        timer_refresh_tick,
    input  dma_lines_t  dma_request_ext,
    input  dma_lines_t  dma_acknowledge_n,
    output dma_lines_t  dma_request,
    input  logic        io_read_n,
    input  logic        io_write_n,
    input  logic        memory_read_n,
    input  logic        memory_write_n,
    input  logic        ram_select_n,
    input  logic        io_channel_ready,
    input  logic        memory_access_ready,
    output logic        processor_ready,
    input  data_byte_t  chipset_data,
    input  logic        chipset_data_valid,
    input  data_byte_t  ram_data,
    input  data_byte_t  ext_data,
    input  logic        ext_direction,
    output data_byte_t  data_to_cpu,
    output logic        data_bus_direction,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  cfg_addr_t   wb_adr,
    input  data_byte_t  wb_dat_w,
    output data_byte_t  wb_dat_r,
    output logic        wb_ack
);

    logic        refresh_enable;
    logic        refresh_served;
    logic        refresh_req;
    wait_count_t wait_states;

    bus_cycle_if u_bus ();

    assign u_bus.io_read_n      = io_read_n;
    assign u_bus.io_write_n     = io_write_n;
    assign u_bus.memory_read_n  = memory_read_n;
    assign u_bus.memory_write_n = memory_write_n;
    assign u_bus.ram_select_n   = ram_select_n;

    // Channel 0 is refresh, the rest come from outside
    assign dma_request = {dma_request_ext[`CHIPSET_DMA_CHANNELS-1:1], refresh_req};

    chipset_config u_chipset_config (
        .clock          (clock),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .refresh_served (refresh_served),
        .refresh_enable (refresh_enable),
        .wait_states    (wait_states)
    );

    refresh_request u_refresh_request (
        .clock              (clock),
        .reset              (reset),
        .timer_refresh_tick (timer_refresh_tick),
        .refresh_enable     (refresh_enable),
        .dma0_acknowledge_n (dma_acknowledge_n[0]),
        .refresh_request    (refresh_req),
        .refresh_served     (refresh_served)
    );

    ready_control u_ready_control (
        .clock               (clock),
        .reset               (reset),
        .bus                 (u_bus.command),
        .wait_states         (wait_states),
        .io_channel_ready    (io_channel_ready),
        .memory_access_ready (memory_access_ready),
        .processor_ready     (processor_ready)
    );

    data_bus_steer u_data_bus_steer (
        .bus                (u_bus.read_path),
        .chipset_data       (chipset_data),
        .chipset_data_valid (chipset_data_valid),
        .ram_data           (ram_data),
        .ext_data           (ext_data),
        .ext_direction      (ext_direction),
        .data_to_cpu        (data_to_cpu),
        .data_bus_direction (data_bus_direction)
    );

endmodule
